//--- compile.f
+incdir+include
source/func_pm_pkg.sv
source/pm_cfg_regs.sv
source/pm_txn_tracker.sv
source/func_pm_fsm.sv
source/func_pm_top.sv
sim/func_pm_checker.sv
sim/func_pm_tb.sv

//--- Bender.yml
package:
  name: func_pm

export_include_dirs:
  - include

sources:
  - source/func_pm_pkg.sv
  - source/pm_cfg_regs.sv
  - source/pm_txn_tracker.sv
  - source/func_pm_fsm.sv
  - source/func_pm_top.sv
  - target: test
    files:
      - sim/func_pm_checker.sv
      - sim/func_pm_tb.sv

//--- sim/func_pm_tb.sv
// Testbench top for the function power-management block, runs the stimulus table against dut_i

`timescale 1ns/1ps

`include "func_pm_macros.svh"

module func_pm_tb;

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 5;
    // Longer than the recovery length plus two
    localparam int SETTLE_CYCLES = 12;
    localparam int NUM_ROWS      = 17;

    // Row operations
    localparam int OP_NONE   = 0;
    localparam int OP_PS_WR  = 1;
    localparam int OP_CMD_WR = 2;
    localparam int OP_MEM    = 3;
    localparam int OP_NP_REQ = 4;
    localparam int OP_NP_CPL = 5;
    localparam int OP_FLR    = 6;
    // PS write, FLR on the following cycle
    localparam int OP_PS_FLR = 7;

    localparam func_pm_pkg::pm_state_t S_UN = func_pm_pkg::PM_D0UNINIT;
    localparam func_pm_pkg::pm_state_t S_AC = func_pm_pkg::PM_D0ACT;
    localparam func_pm_pkg::pm_state_t S_HO = func_pm_pkg::PM_D3HOT;

    logic                   prim_nonflr_clk = 1'b0;
    logic                   prim_gated_rst_b;
    logic                   cfg_wr;
    logic                   cfg_wr_sel_pmcsr;
    logic                   cfg_wr_sel_cmd;
    func_pm_pkg::pm_ps_t    cfg_wr_ps;
    logic                   cfg_wr_bme;
    logic                   mem_wr_hit;
    logic                   np_req;
    logic                   np_cpl;
    logic                   power_down;
    logic                   pm_enable;
    logic                   flr;
    logic                   ps_cpl_sent;
    func_pm_pkg::pm_state_t pm_state;
    logic                   pm_fsm_rst;
    logic                   ps_cpl_sent_ack;
    func_pm_pkg::pm_ps_t    csr_ppmcsr_ps;
    logic                   csr_bme;

    // ------------------------------
    // Stimulus table
    // ------------------------------

    string                  row_name  [NUM_ROWS];
    int                     row_op    [NUM_ROWS];
    logic [1:0]             row_data  [NUM_ROWS];
    // Levels {power_down, pm_enable, ps_cpl_sent}
    logic [2:0]             row_lvl   [NUM_ROWS];
    func_pm_pkg::pm_state_t row_state [NUM_ROWS];
    func_pm_pkg::pm_ps_t    row_ps    [NUM_ROWS];
    logic                   row_bme   [NUM_ROWS];
    int                     row_rst   [NUM_ROWS];
    int                     row_ack   [NUM_ROWS];
    // States passed through, bit index is the state encoding
    logic [3:0]             row_seen  [NUM_ROWS];

    int          n_rows      = 0;
    int          outstanding = 0;
    logic [31:0] lfsr        = 32'h95e2;

    func_pm_top dut_i (.*);

    func_pm_checker checker_i (.*);

    initial begin
        forever #(CLK_PERIOD / 2) prim_nonflr_clk = ~prim_nonflr_clk;
    end

    // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One step per bit taken
    task take_bits(input int nbits, output int value);
        value = 0;
        for (int b = 0; b < nbits; b++) begin
            lfsr  = lfsr_next(lfsr);
            value = (value << 1) | lfsr[0];
        end
    endtask

    task add_row(input string name, input int op, input logic [1:0] data, input logic [2:0] lvl,
                 input func_pm_pkg::pm_state_t st, input func_pm_pkg::pm_ps_t ps,
                 input logic bme, input int rst, input int ack, input logic [3:0] seen);
        row_name[n_rows]  = name;
        row_op[n_rows]    = op;
        row_data[n_rows]  = data;
        row_lvl[n_rows]   = lvl;
        row_state[n_rows] = st;
        row_ps[n_rows]    = ps;
        row_bme[n_rows]   = bme;
        row_rst[n_rows]   = rst;
        row_ack[n_rows]   = ack;
        row_seen[n_rows]  = seen;
        n_rows++;
    endtask

    task fill_table();
        // Enabling events from D0-uninit
        add_row("reset_values", OP_NONE, 0, 3'b010, S_UN, 0, 0, 0, 0, 4'b0001);
        add_row("bme_set", OP_CMD_WR, 1, 3'b010, S_AC, 0, 1, 0, 0, 4'b0011);
        add_row("flr_d0act", OP_FLR, 0, 3'b010, S_UN, 0, 0, 1, 1, 4'b0011);
        add_row("mem_hit", OP_MEM, 0, 3'b010, S_AC, 0, 0, 0, 0, 4'b0011);
        // Any nonzero outstanding count blocks D0 to D3
        add_row("np_burst", OP_NP_REQ, 0, 3'b010, S_AC, 0, 0, 0, 0, 4'b0010);
        add_row("ps_d3_blocked", OP_PS_WR, `FUNC_PM_PS_D3, 3'b011, S_AC, 3, 0, 0, 0, 4'b0010);
        add_row("np_drain", OP_NP_CPL, 0, 3'b011, S_HO, 3, 0, 0, 1, 4'b0110);
        add_row("ps_reserved", OP_PS_WR, 2'd2, 3'b010, S_HO, 3, 0, 0, 0, 4'b0100);
        // PS still reads D3, so D3-cold bounces back to D3-hot each cycle
        add_row("pd_cold_bounce", OP_NONE, 0, 3'b110, S_HO, 3, 0, 0, 0, 4'b1100);
        add_row("ps_d3_rewrite", OP_PS_WR, `FUNC_PM_PS_D3, 3'b010, S_HO, 3, 0, 0, 0, 4'b0100);
        add_row("ps_d0_recover", OP_PS_WR, `FUNC_PM_PS_D0, 3'b010, S_AC, 0, 0, 0, 0, 4'b0110);
        add_row("ps_d3_again", OP_PS_WR, `FUNC_PM_PS_D3, 3'b011, S_HO, 3, 0, 0, 1, 4'b0110);
        add_row("bme_in_d3hot", OP_CMD_WR, 1, 3'b010, S_HO, 3, 1, 0, 0, 4'b0100);
        // FLR lands while recovery runs and waits for it
        add_row("flr_pending", OP_PS_FLR, `FUNC_PM_PS_D0, 3'b010, S_UN, 0, 0, 1, 0, 4'b0101);
        add_row("mem_hit_again", OP_MEM, 0, 3'b010, S_AC, 0, 0, 0, 0, 4'b0011);
        add_row("pm_disable", OP_NONE, 0, 3'b000, S_UN, 0, 0, 0, 1, 4'b0011);
        add_row("flr_d0uninit", OP_FLR, 0, 3'b010, S_UN, 0, 0, 1, 0, 4'b0001);
    endtask

    // ------------------------------
    // Drivers
    // ------------------------------

    task clear_strobes();
        cfg_wr           = 1'b0;
        cfg_wr_sel_pmcsr = 1'b0;
        cfg_wr_sel_cmd   = 1'b0;
        cfg_wr_ps        = '0;
        cfg_wr_bme       = 1'b0;
        mem_wr_hit       = 1'b0;
        np_req           = 1'b0;
        np_cpl           = 1'b0;
        flr              = 1'b0;
    endtask

    // Starts on a falling edge, ends on one, gives back the cycles it took
    task apply_op(input int op, input logic [1:0] data, output int used);
        int n;
        n    = 0;
        used = 0;
        case (op)
            OP_PS_WR, OP_PS_FLR: begin
                cfg_wr           = 1'b1;
                cfg_wr_sel_pmcsr = 1'b1;
                cfg_wr_ps        = data;
                used             = 1;
            end
            OP_CMD_WR: begin
                cfg_wr         = 1'b1;
                cfg_wr_sel_cmd = 1'b1;
                cfg_wr_bme     = data[0];
                used           = 1;
            end
            OP_MEM: begin
                mem_wr_hit = 1'b1;
                used       = 1;
            end
            OP_FLR: begin
                flr  = 1'b1;
                used = 1;
            end
            OP_NP_REQ: begin
                // 1 to 7 back-to-back requests
                while (n == 0) begin
                    take_bits(3, n);
                end
                np_req      = 1'b1;
                outstanding = outstanding + n;
                used        = n;
            end
            OP_NP_CPL: begin
                np_cpl      = (outstanding > 0);
                used        = outstanding;
                outstanding = 0;
            end
            default: begin
                used = 0;
            end
        endcase
        repeat (used) @(negedge prim_nonflr_clk);
        if (op == OP_PS_FLR) begin
            clear_strobes();
            flr = 1'b1;
            @(negedge prim_nonflr_clk);
            used = 2;
        end
        clear_strobes();
    endtask

    // ------------------------------
    // Sequence
    // ------------------------------

    initial begin
        int used;
        prim_gated_rst_b = 1'b0;
        power_down       = 1'b0;
        pm_enable        = 1'b1;
        ps_cpl_sent      = 1'b0;
        clear_strobes();
        fill_table();
        repeat (RESET_CYCLES) @(negedge prim_nonflr_clk);
        prim_gated_rst_b = 1'b1;
        @(negedge prim_nonflr_clk);
        for (int i = 0; i < n_rows; i++) begin
            checker_i.open_window();
            {power_down, pm_enable, ps_cpl_sent} = row_lvl[i];
            apply_op(row_op[i], row_data[i], used);
            repeat (SETTLE_CYCLES - used) @(negedge prim_nonflr_clk);
            checker_i.compare_row(row_name[i], row_state[i], row_ps[i], row_bme[i],
                                  row_rst[i], row_ack[i], row_seen[i]);
        end
        checker_i.print_summary();
        if (checker_i.error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Watchdog, table length plus margin
    initial begin
        #((NUM_ROWS * SETTLE_CYCLES + RESET_CYCLES + 100) * CLK_PERIOD);
        $display("Watchdog timeout: the stimulus table did not complete in time");
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- sim/func_pm_checker.sv
// Checker beside the DUT in func_pm_tb, counts strobes per table row and compares settled outputs

`timescale 1ns/1ps

module func_pm_checker (
     input logic                   prim_nonflr_clk
    ,input logic                   prim_gated_rst_b
    ,input func_pm_pkg::pm_state_t pm_state
    ,input logic                   pm_fsm_rst
    ,input logic                   ps_cpl_sent_ack
    ,input func_pm_pkg::pm_ps_t    csr_ppmcsr_ps
    ,input logic                   csr_bme
);

    int         error_count  = 0;
    int         rows_checked = 0;
    int         rst_count    = 0;
    int         ack_count    = 0;
    logic       window_open  = 1'b0;
    // One bit per state encoding
    logic [3:0] seen         = 4'b0000;

    // ------------------------------
    // Window sampling
    // ------------------------------

    // Strobes are combinational from state, so the rising edge sees them settled
    always @(posedge prim_nonflr_clk) begin
        if (window_open && prim_gated_rst_b) begin
            seen = seen | (4'b0001 << pm_state);
            if (pm_fsm_rst) begin
                rst_count++;
            end
            if (ps_cpl_sent_ack) begin
                ack_count++;
            end
        end
    end

    // Called on the falling edge where a row is driven
    task open_window();
        rst_count   = 0;
        ack_count   = 0;
        seen        = 4'b0001 << pm_state;
        window_open = 1'b1;
    endtask

    // ------------------------------
    // Comparison
    // ------------------------------

    task check_value(input string name, input string what, input int expected, input int actual);
        if (expected != actual) begin
            $display("ERROR %s: %s expected %0d actual %0d", name, what, expected, actual);
            error_count++;
        end
    endtask

    task compare_row(input string name, input func_pm_pkg::pm_state_t exp_state,
                     input func_pm_pkg::pm_ps_t exp_ps, input logic exp_bme,
                     input int exp_rst, input int exp_ack, input logic [3:0] exp_seen);
        window_open = 1'b0;
        // Final state counts as visited
        seen = seen | (4'b0001 << pm_state);
        check_value(name, "pm_state", exp_state, pm_state);
        check_value(name, "csr_ppmcsr_ps", exp_ps, csr_ppmcsr_ps);
        check_value(name, "csr_bme", exp_bme, csr_bme);
        check_value(name, "pm_fsm_rst pulses", exp_rst, rst_count);
        check_value(name, "ps_cpl_sent_ack pulses", exp_ack, ack_count);
        check_value(name, "visited state mask", exp_seen, seen);
        rows_checked++;
    endtask

    task print_summary();
        $display("Checker: %0d rows compared, %0d errors", rows_checked, error_count);
    endtask

endmodule

//--- source/func_pm_top.sv
// Top of the function power-management block, joining config registers, tracker and D-state FSM

`timescale 1ns/1ps

module func_pm_top (
    // Clock and reset
     input  logic                   prim_nonflr_clk
    ,input  logic                   prim_gated_rst_b

    // Pre-decoded configuration write
    ,input  logic                   cfg_wr
    ,input  logic                   cfg_wr_sel_pmcsr
    ,input  logic                   cfg_wr_sel_cmd
    ,input  func_pm_pkg::pm_ps_t    cfg_wr_ps
    ,input  logic                   cfg_wr_bme

    // Traffic and link events
    ,input  logic                   mem_wr_hit
    ,input  logic                   np_req
    ,input  logic                   np_cpl
    ,input  logic                   power_down
    ,input  logic                   pm_enable
    ,input  logic                   flr
    ,input  logic                   ps_cpl_sent

    // Status and strobes
    ,output func_pm_pkg::pm_state_t pm_state
    ,output logic                   pm_fsm_rst
    ,output logic                   ps_cpl_sent_ack
    ,output func_pm_pkg::pm_ps_t    csr_ppmcsr_ps
    ,output logic                   csr_bme
);

    logic bme_or_mem_wr;
    logic ps_wr_d0;
    logic pm_fsm_d0tod3_ok;
    logic pm_fsm_d3tod0_ok;

    // ------------------------------
    // Config registers
    // ------------------------------

    pm_cfg_regs cfg_regs_i (
         .prim_nonflr_clk  (prim_nonflr_clk)
        ,.prim_gated_rst_b (prim_gated_rst_b)
        ,.cfg_wr           (cfg_wr)
        ,.cfg_wr_sel_pmcsr (cfg_wr_sel_pmcsr)
        ,.cfg_wr_sel_cmd   (cfg_wr_sel_cmd)
        ,.cfg_wr_ps        (cfg_wr_ps)
        ,.cfg_wr_bme       (cfg_wr_bme)
        ,.mem_wr_hit       (mem_wr_hit)
        ,.pm_fsm_rst       (pm_fsm_rst)
        ,.csr_ppmcsr_ps    (csr_ppmcsr_ps)
        ,.csr_bme          (csr_bme)
        ,.bme_or_mem_wr    (bme_or_mem_wr)
        ,.ps_wr_d0         (ps_wr_d0)
    );

    // Outstanding requests and recovery
    pm_txn_tracker txn_tracker_i (
         .prim_nonflr_clk  (prim_nonflr_clk)
        ,.prim_gated_rst_b (prim_gated_rst_b)
        ,.np_req           (np_req)
        ,.np_cpl           (np_cpl)
        ,.ps_wr_d0         (ps_wr_d0)
        ,.pm_fsm_d0tod3_ok (pm_fsm_d0tod3_ok)
        ,.pm_fsm_d3tod0_ok (pm_fsm_d3tod0_ok)
    );

    // D-state machine
    func_pm_fsm fsm_i (
         .prim_nonflr_clk  (prim_nonflr_clk)
        ,.prim_gated_rst_b (prim_gated_rst_b)
        ,.power_down       (power_down)
        ,.pm_enable        (pm_enable)
        ,.csr_ppmcsr_ps    (csr_ppmcsr_ps)
        ,.flr              (flr)
        ,.bme_or_mem_wr    (bme_or_mem_wr)
        ,.pm_fsm_d0tod3_ok (pm_fsm_d0tod3_ok)
        ,.pm_fsm_d3tod0_ok (pm_fsm_d3tod0_ok)
        ,.ps_cpl_sent      (ps_cpl_sent)
        ,.pm_fsm_rst       (pm_fsm_rst)
        ,.pm_state         (pm_state)
        ,.ps_cpl_sent_ack  (ps_cpl_sent_ack)
    );

endmodule

//--- source/func_pm_fsm.sv
// D-state machine of the function that tracks D0 and D3 and issues reset and PS acks

`timescale 1ns/1ps

`include "func_pm_macros.svh"

module func_pm_fsm (
    // Clock and reset
     input  logic                   prim_nonflr_clk
    ,input  logic                   prim_gated_rst_b

    // Link and enable levels
    ,input  logic                   power_down
    ,input  logic                   pm_enable

    // Register state and events
    ,input  func_pm_pkg::pm_ps_t    csr_ppmcsr_ps
    ,input  logic                   flr
    ,input  logic                   bme_or_mem_wr

    // Permissions from the tracker
    ,input  logic                   pm_fsm_d0tod3_ok
    ,input  logic                   pm_fsm_d3tod0_ok

    // Completion of the PS write is out
    ,input  logic                   ps_cpl_sent

    // State and strobes
    ,output logic                   pm_fsm_rst
    ,output func_pm_pkg::pm_state_t pm_state
    ,output logic                   ps_cpl_sent_ack
);

    func_pm_pkg::pm_state_t state_q;
    func_pm_pkg::pm_state_t state_d;
    logic                   flr_pending_q;
    logic                   flr_pending_d;
    logic                   ps_is_d0;
    logic                   ps_is_d3;

    assign ps_is_d0 = (csr_ppmcsr_ps == `FUNC_PM_PS_D0);
    assign ps_is_d3 = (csr_ppmcsr_ps == `FUNC_PM_PS_D3);

    // ------------------------------
    // Next state
    // ------------------------------

    always_comb begin
        // Hold state by default with strobes idle
        state_d         = state_q;
        flr_pending_d   = flr_pending_q;
        pm_fsm_rst      = 1'b0;
        ps_cpl_sent_ack = 1'b0;

        case (state_q)
            // Link in L2/L3 and the function may lose power
            func_pm_pkg::PM_D3COLD: begin
                if (!pm_enable) begin
                    state_d = func_pm_pkg::PM_D0UNINIT;
                end else if (ps_is_d3) begin
                    state_d = func_pm_pkg::PM_D3HOT;
                end else if (pm_fsm_d3tod0_ok && ps_is_d0) begin
                    state_d = func_pm_pkg::PM_D0UNINIT;
                end
            end

            // Config space kept with only config and messages served
            func_pm_pkg::PM_D3HOT: begin
                if (flr_pending_q || flr || !pm_enable) begin
                    // FLR waits for recovery to finish
                    if (pm_fsm_d3tod0_ok) begin
                        state_d       = func_pm_pkg::PM_D0UNINIT;
                        pm_fsm_rst    = flr_pending_q | flr;
                        flr_pending_d = 1'b0;
                    end else begin
                        flr_pending_d = flr_pending_q | flr;
                    end
                end else if (power_down) begin
                    state_d = func_pm_pkg::PM_D3COLD;
                end else if (pm_fsm_d3tod0_ok && ps_is_d0) begin
                    state_d = func_pm_pkg::PM_D0ACT;
                end
            end

            // Waiting for BME or a BAR hit
            func_pm_pkg::PM_D0UNINIT: begin
                if (!pm_enable || flr) begin
                    // Stay here while an FLR still resets the function
                    pm_fsm_rst = flr;
                end else if (bme_or_mem_wr && !power_down) begin
                    state_d = func_pm_pkg::PM_D0ACT;
                end
            end

            // Fully operational
            func_pm_pkg::PM_D0ACT: begin
                if (!pm_enable || flr) begin
                    state_d         = func_pm_pkg::PM_D0UNINIT;
                    pm_fsm_rst      = flr;
                    ps_cpl_sent_ack = 1'b1;
                end else if (pm_fsm_d0tod3_ok && ps_is_d3 && ps_cpl_sent) begin
                    state_d         = func_pm_pkg::PM_D3HOT;
                    ps_cpl_sent_ack = 1'b1;
                end else if (pm_fsm_d0tod3_ok && power_down && ps_cpl_sent) begin
                    state_d         = func_pm_pkg::PM_D3COLD;
                    ps_cpl_sent_ack = 1'b1;
                end
            end

            default: begin
                state_d = func_pm_pkg::PM_D0UNINIT;
            end
        endcase
    end

    // ------------------------------
    // State registers
    // ------------------------------

    // Out of reset the function is D0 uninitialized
    always_ff @(posedge prim_nonflr_clk or negedge prim_gated_rst_b) begin
        if (!prim_gated_rst_b) begin
            state_q       <= func_pm_pkg::PM_D0UNINIT;
            flr_pending_q <= 1'b0;
        end else begin
            state_q       <= state_d;
            flr_pending_q <= flr_pending_d;
        end
    end

    assign pm_state = state_q;

    // ------------------------------
    // Checks
    // ------------------------------

    // Function reset only follows a live or remembered FLR and lands in D0-uninit
    a_rst_has_flr: assert property (@(posedge prim_nonflr_clk) disable iff (!prim_gated_rst_b)
        pm_fsm_rst |-> (flr || flr_pending_q) ##1
            (state_q == func_pm_pkg::PM_D0UNINIT && !flr_pending_q));

    // A pending FLR is only held while parked in D3-hot
    a_pending_in_d3hot: assert property (@(posedge prim_nonflr_clk)
        disable iff (!prim_gated_rst_b)
        flr_pending_q |-> (state_q == func_pm_pkg::PM_D3HOT));

endmodule

//--- source/pm_txn_tracker.sv
// Outstanding non-posted counter and D3-to-D0 recovery timer giving the FSM its permissions

`timescale 1ns/1ps

`include "func_pm_macros.svh"

module pm_txn_tracker (
    // Clock and reset
     input  logic prim_nonflr_clk
    ,input  logic prim_gated_rst_b

    // Non-posted traffic
    ,input  logic np_req
    ,input  logic np_cpl

    // PMCSR write of D0
    ,input  logic ps_wr_d0

    // Permissions to the FSM
    ,output logic pm_fsm_d0tod3_ok
    ,output logic pm_fsm_d3tod0_ok
);

    // Timer runs 0 .. N-1, so the last value is reached N cycles after the strobe
    localparam func_pm_pkg::recovery_cnt_t RECOV_LAST =
        func_pm_pkg::recovery_cnt_t'(`FUNC_PM_RECOVERY_CYCLES - 1);

    // Largest count the counter can hold
    localparam func_pm_pkg::outstanding_cnt_t OUTST_MAX = '1;

    func_pm_pkg::outstanding_cnt_t outst_q;
    func_pm_pkg::recovery_cnt_t    recov_q;

    // ------------------------------
    // Outstanding requests
    // ------------------------------

    always_ff @(posedge prim_nonflr_clk or negedge prim_gated_rst_b) begin
        if (!prim_gated_rst_b) begin
            outst_q <= '0;
        end else begin
            // Request and completion together leave the count alone
            case ({np_req, np_cpl})
                2'b10:   outst_q <= outst_q + 1'b1;
                2'b01:   outst_q <= outst_q - 1'b1;
                default: outst_q <= outst_q;
            endcase
        end
    end

    // D0 to D3 only with nothing in flight
    assign pm_fsm_d0tod3_ok = (outst_q == '0);

    // ------------------------------
    // Recovery timer
    // ------------------------------

    // Starts saturated, so D3-to-D0 is allowed out of reset
    always_ff @(posedge prim_nonflr_clk or negedge prim_gated_rst_b) begin
        if (!prim_gated_rst_b) begin
            recov_q <= RECOV_LAST;
        end else if (ps_wr_d0) begin
            recov_q <= '0;
        end else if (recov_q != RECOV_LAST) begin
            recov_q <= recov_q + 1'b1;
        end
    end

    assign pm_fsm_d3tod0_ok = (recov_q == RECOV_LAST);

    // ------------------------------
    // Checks
    // ------------------------------

    // A completion never arrives without a request in flight
    a_no_underflow: assert property (@(posedge prim_nonflr_clk) disable iff (!prim_gated_rst_b)
        (np_cpl && !np_req) |-> (outst_q != '0));

    // The requester never exceeds the counter range
    a_no_overflow: assert property (@(posedge prim_nonflr_clk) disable iff (!prim_gated_rst_b)
        (np_req && !np_cpl) |-> (outst_q != OUTST_MAX));

endmodule

//--- source/pm_cfg_regs.sv
// PMCSR.PS and BME registers written by pre-decoded config strobes, feeding the D-state FSM

`timescale 1ns/1ps

`include "func_pm_macros.svh"

module pm_cfg_regs (
    // Clock and reset
     input  logic                prim_nonflr_clk
    ,input  logic                prim_gated_rst_b

    // Pre-decoded configuration write
    ,input  logic                cfg_wr
    ,input  logic                cfg_wr_sel_pmcsr
    ,input  logic                cfg_wr_sel_cmd
    ,input  func_pm_pkg::pm_ps_t cfg_wr_ps
    ,input  logic                cfg_wr_bme

    // Memory write that hit a BAR
    ,input  logic                mem_wr_hit

    // Function reset from the FSM
    ,input  logic                pm_fsm_rst

    // Register values and events
    ,output func_pm_pkg::pm_ps_t csr_ppmcsr_ps
    ,output logic                csr_bme
    ,output logic                bme_or_mem_wr
    ,output logic                ps_wr_d0
);

    logic                pmcsr_wr;
    logic                cmd_wr;
    logic                ps_legal;
    func_pm_pkg::pm_ps_t ps_q;
    logic                bme_q;

    // ------------------------------
    // Write decode
    // ------------------------------

    assign pmcsr_wr = cfg_wr & cfg_wr_sel_pmcsr;
    assign cmd_wr   = cfg_wr & cfg_wr_sel_cmd;

    // Only D0 and D3 are accepted, reserved values keep the old PS
    assign ps_legal = (cfg_wr_ps == `FUNC_PM_PS_D0) | (cfg_wr_ps == `FUNC_PM_PS_D3);

    // ------------------------------
    // Registers
    // ------------------------------

    always_ff @(posedge prim_nonflr_clk or negedge prim_gated_rst_b) begin
        if (!prim_gated_rst_b) begin
            ps_q  <= `FUNC_PM_PS_D0;
            bme_q <= 1'b0;
        end else begin
            // Function reset wins over a write in the same cycle
            if (pm_fsm_rst) begin
                ps_q  <= `FUNC_PM_PS_D0;
                bme_q <= 1'b0;
            end else begin
                if (pmcsr_wr && ps_legal) begin
                    ps_q <= cfg_wr_ps;
                end
                if (cmd_wr) begin
                    bme_q <= cfg_wr_bme;
                end
            end
        end
    end

    assign csr_ppmcsr_ps = ps_q;
    assign csr_bme       = bme_q;

    // ------------------------------
    // Events
    // ------------------------------

    // Enabling event, BME going 0 to 1 or any BAR hit
    assign bme_or_mem_wr = (cmd_wr & cfg_wr_bme & ~bme_q) | mem_wr_hit;

    // Restarts the recovery timer in the tracker
    assign ps_wr_d0 = pmcsr_wr & (cfg_wr_ps == `FUNC_PM_PS_D0);

    // Decoder hands over one target per write
    a_one_sel: assert property (@(posedge prim_nonflr_clk) disable iff (!prim_gated_rst_b)
        cfg_wr |-> !(cfg_wr_sel_pmcsr && cfg_wr_sel_cmd));

endmodule

//--- source/func_pm_pkg.sv
// Shared types for the function power-management block, referenced by scoped name

`include "func_pm_macros.svh"

package func_pm_pkg;

    // ------------------------------
    // Device power state
    // ------------------------------

    // Encoding is visible on the pm_state output
    typedef enum logic [1:0] {
        PM_D0UNINIT = 2'd0,
        PM_D0ACT    = 2'd1,
        PM_D3HOT    = 2'd2,
        PM_D3COLD   = 2'd3
    } pm_state_t;

    // ------------------------------
    // Vector types
    // ------------------------------

    // PMCSR power-state field
    typedef logic [1:0] pm_ps_t;

    // Outstanding non-posted request count
    typedef logic [`FUNC_PM_OUTST_W-1:0] outstanding_cnt_t;

    // D3-to-D0 recovery timer
    typedef logic [`FUNC_PM_RECOV_W-1:0] recovery_cnt_t;

endpackage

//--- include/func_pm_macros.svh
// Sizing and encoding macros for the function power-management block, included by its sources

`ifndef FUNC_PM_MACROS_SVH
`define FUNC_PM_MACROS_SVH

// ------------------------------
// Recovery and counter sizing
// ------------------------------

// Cycles from a PS write to D0 until D3-to-D0 is allowed
`define FUNC_PM_RECOVERY_CYCLES 8

// Width of the outstanding non-posted counter
`define FUNC_PM_OUTST_W 4
// Width of the recovery timer, must hold the recovery length
`define FUNC_PM_RECOV_W 4

// PMCSR.PS encodings in use, D1 and D2 are not supported
`define FUNC_PM_PS_D0 2'd0
`define FUNC_PM_PS_D3 2'd3

`endif
